/* quant_pkg.sv */
package quant_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // row geometry and datapath widths
  //////////////////////////////////////////////////////////////////////////////

  localparam int lanes       = 8;
  // one channel group in 1x8 mode
  localparam int half_lanes  = 4;
  // 16-bit partial sum plus 8 bits of headroom
  localparam int psum_width  = 24;
  localparam int scale_width = 16;
  localparam int prod_width  = 40;
  localparam int bias_width  = 8;
  localparam int shift_width = 5;
  localparam int out_width   = 8;

  // int8 saturation bounds
  localparam int qout_max = 127;
  localparam int qout_min = -128;

  // per-lane scalar types
  typedef logic signed [psum_width-1:0]  psum_t;
  typedef logic signed [prod_width-1:0]  prod_t;
  typedef logic signed [bias_width-1:0]  bias_t;
  typedef logic signed [scale_width-1:0] scale_t;
  typedef logic signed [out_width-1:0]   qout_t;
  typedef logic [shift_width-1:0]        shift_t;
  typedef logic [3:0]                    mode_t;

  // array precision modes
  localparam mode_t mode_8x8 = 4'd0;
  localparam mode_t mode_1x8 = 4'd1;

  // config write port
  typedef logic [2:0]  cfg_addr_t;
  typedef logic [15:0] cfg_data_t;

  localparam cfg_addr_t addr_mode  = 3'd0;
  localparam cfg_addr_t addr_scale = 3'd1;
  localparam cfg_addr_t addr_shift = 3'd2;
  localparam cfg_addr_t addr_bias  = 3'd3;

  // flat row vectors, lane 0 in the low bits
  typedef logic [lanes*psum_width-1:0] psum_vec_t;
  typedef logic [lanes*prod_width-1:0] prod_vec_t;
  typedef logic [lanes*out_width-1:0]  qout_vec_t;

endpackage

/* quant_cfg_if.sv */
interface quant_cfg_if;

  // layer configuration, static while rows are in flight
  quant_pkg::mode_t  mode;
  quant_pkg::scale_t scale;
  quant_pkg::shift_t shift;

  // bias0 feeds the lower lane group, bias1 the upper one in 1x8 mode
  quant_pkg::bias_t  bias0;
  quant_pkg::bias_t  bias1;

  // register block side
  modport regs (
    output mode,
    output scale,
    output shift,
    output bias0,
    output bias1
  );

  // pipeline stage side
  modport stage (
    input mode,
    input scale,
    input shift,
    input bias0,
    input bias1
  );

endinterface

/* quant_cfg_regs.sv */
module quant_cfg_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cfg_wr,
  input  quant_pkg::cfg_addr_t cfg_addr,
  input  quant_pkg::cfg_data_t cfg_wdata,
  quant_cfg_if.regs            cfg
);

  //////////////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////////////

  // one register per address, narrower fields take the low data bits
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.mode  <= '0;
      cfg.scale <= '0;
      cfg.shift <= '0;
      cfg.bias0 <= '0;
      cfg.bias1 <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        quant_pkg::addr_mode: begin
          cfg.mode <= cfg_wdata[3:0];
        end
        quant_pkg::addr_scale: begin
          cfg.scale <= cfg_wdata[quant_pkg::scale_width-1:0];
        end
        quant_pkg::addr_shift: begin
          cfg.shift <= cfg_wdata[quant_pkg::shift_width-1:0];
        end
        quant_pkg::addr_bias: begin
          // bias pair packed in one write
          cfg.bias0 <= cfg_wdata[quant_pkg::bias_width-1:0];
          cfg.bias1 <= cfg_wdata[2*quant_pkg::bias_width-1:quant_pkg::bias_width];
        end
        default: begin
          // unmapped addresses are dropped
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////////////

  // software should never touch the unmapped upper addresses
  a_addr_in_range: assert property (
    @(posedge clk) disable iff (reset)
    cfg_wr |-> (cfg_addr <= quant_pkg::addr_bias)
  ) else $error("config write to unmapped address %0d", cfg_addr);

  // a write is a single-cycle strobe with a known address
  a_addr_known: assert property (
    @(posedge clk) disable iff (reset)
    cfg_wr |-> !$isunknown(cfg_addr)
  ) else $error("config write with unknown address");

endmodule

/* quant_scale_mult.sv */
module quant_scale_mult (
  input  logic                 clk,
  input  logic                 reset,
  quant_cfg_if.stage           cfg,
  input  logic                 acc_valid,
  input  quant_pkg::psum_vec_t acc_vec,
  output logic                 prod_valid,
  output quant_pkg::prod_vec_t prod_vec
);

  quant_pkg::prod_vec_t prod_next;

  //////////////////////////////////////////////////////////////////////////////
  // per-lane multiply by scale E
  //////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < quant_pkg::lanes; i++) begin : g_lane
    quant_pkg::psum_t lane_psum;
    quant_pkg::prod_t lane_prod;

    assign lane_psum = acc_vec[i*quant_pkg::psum_width +: quant_pkg::psum_width];

    // both operands sign extended to 40 bits, product fits without loss
    assign lane_prod = quant_pkg::prod_t'(lane_psum) * quant_pkg::prod_t'(cfg.scale);

    assign prod_next[i*quant_pkg::prod_width +: quant_pkg::prod_width] = lane_prod;
  end

  //////////////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////////////

  // valid is a plain one-cycle delay
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= acc_valid;
    end
  end

  // data holds between rows
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_vec <= '0;
    end else if (acc_valid) begin
      prod_vec <= prod_next;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////////////

  // an X on the row strobe would poison the whole valid chain
  a_acc_valid_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(acc_valid)
  ) else $error("acc_valid is unknown");

endmodule

/* quant_bias_add.sv */
module quant_bias_add (
  input  logic                 clk,
  input  logic                 reset,
  quant_cfg_if.stage           cfg,
  input  logic                 prod_valid,
  input  quant_pkg::prod_vec_t prod_vec,
  output logic                 sum_valid,
  output quant_pkg::prod_vec_t sum_vec
);

  quant_pkg::prod_vec_t sum_next;

  //////////////////////////////////////////////////////////////////////////////
  // per-lane bias add with mode select
  //////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < quant_pkg::lanes; i++) begin : g_lane
    quant_pkg::prod_t lane_prod;
    quant_pkg::bias_t lane_bias;
    quant_pkg::prod_t lane_sum;
    logic             lane_keep;

    assign lane_prod = prod_vec[i*quant_pkg::prod_width +: quant_pkg::prod_width];

    // lower group uses channel 0, upper group channel 1
    assign lane_bias = (i < quant_pkg::half_lanes) ? cfg.bias0 : cfg.bias1;

    // bias sign extended, sum wraps at 40 bits
    assign lane_sum = lane_prod + quant_pkg::prod_t'(lane_bias);

    // which lanes carry data in the current mode
    always_comb begin
      case (cfg.mode)
        quant_pkg::mode_8x8: begin
          lane_keep = (i < quant_pkg::half_lanes);
        end
        quant_pkg::mode_1x8: begin
          lane_keep = 1'b1;
        end
        default: begin
          lane_keep = 1'b0;
        end
      endcase
    end

    assign sum_next[i*quant_pkg::prod_width +: quant_pkg::prod_width] =
      lane_keep ? lane_sum : '0;
  end

  //////////////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= prod_valid;
    end
  end

  // hold the last row when no new product arrives
  always_ff @(posedge clk) begin
    if (reset) begin
      sum_vec <= '0;
    end else if (prod_valid) begin
      sum_vec <= sum_next;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////////////

  // mode and bias pair must not move under a row in this stage
  a_cfg_stable: assert property (
    @(posedge clk) disable iff (reset)
    prod_valid |-> ($stable(cfg.mode) && $stable(cfg.bias0) && $stable(cfg.bias1))
  ) else $error("config changed while a row was in the bias stage");

endmodule

/* quant_requant.sv */
module quant_requant (
  input  logic                 clk,
  input  logic                 reset,
  quant_cfg_if.stage           cfg,
  input  logic                 sum_valid,
  input  quant_pkg::prod_vec_t sum_vec,
  output logic                 out_valid,
  output quant_pkg::qout_vec_t out_vec
);

  quant_pkg::qout_vec_t out_next;

  //////////////////////////////////////////////////////////////////////////////
  // round, shift and saturate per lane
  //////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < quant_pkg::lanes; i++) begin : g_lane
    quant_pkg::prod_t                     lane_sum;
    // one guard bit so the rounding add never overflows
    logic signed [quant_pkg::prod_width:0] lane_ext;
    logic signed [quant_pkg::prod_width:0] lane_rnd;
    logic signed [quant_pkg::prod_width:0] lane_shr;
    quant_pkg::qout_t                     lane_q;

    assign lane_sum = sum_vec[i*quant_pkg::prod_width +: quant_pkg::prod_width];
    assign lane_ext = {lane_sum[quant_pkg::prod_width-1], lane_sum};

    // add half an lsb of the result, so ties go toward positive
    always_comb begin
      if (cfg.shift == '0) begin
        lane_rnd = lane_ext;
      end else begin
        lane_rnd = lane_ext + ((quant_pkg::prod_width+1)'(1) << (cfg.shift - 1'b1));
      end
    end

    assign lane_shr = lane_rnd >>> cfg.shift;

    // clamp into int8
    always_comb begin
      if (lane_shr > quant_pkg::qout_max) begin
        lane_q = quant_pkg::qout_t'(quant_pkg::qout_max);
      end else if (lane_shr < quant_pkg::qout_min) begin
        lane_q = quant_pkg::qout_t'(quant_pkg::qout_min);
      end else begin
        lane_q = lane_shr[quant_pkg::out_width-1:0];
      end
    end

    assign out_next[i*quant_pkg::out_width +: quant_pkg::out_width] = lane_q;
  end

  //////////////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_vec <= '0;
    end else if (sum_valid) begin
      out_vec <= out_next;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////////////

  // a delivered row must be fully known, end to end through all stages
  a_out_known: assert property (
    @(posedge clk) disable iff (reset)
    out_valid |-> !$isunknown(out_vec)
  ) else $error("out_vec has unknown bits while out_valid is high");

endmodule

/* quant_post_top.sv */
module quant_post_top (
  input  logic                 clk,
  input  logic                 reset,

  // config write strobe
  input  logic                 cfg_wr,
  input  quant_pkg::cfg_addr_t cfg_addr,
  input  quant_pkg::cfg_data_t cfg_wdata,

  // rows from the array
  input  logic                 acc_valid,
  input  quant_pkg::psum_vec_t acc_vec,

  // quantized rows, three cycles later
  output logic                 out_valid,
  output quant_pkg::qout_vec_t out_vec
);

  // stage links
  logic                 prod_valid;
  quant_pkg::prod_vec_t prod_vec;
  logic                 sum_valid;
  quant_pkg::prod_vec_t sum_vec;

  quant_cfg_if cfg ();

  quant_cfg_regs u_cfg_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  // stage 1: psum * E
  quant_scale_mult u_scale_mult (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .acc_valid  (acc_valid),
    .acc_vec    (acc_vec),
    .prod_valid (prod_valid),
    .prod_vec   (prod_vec)
  );

  // stage 2: + bias by mode
  quant_bias_add u_bias_add (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .prod_valid (prod_valid),
    .prod_vec   (prod_vec),
    .sum_valid  (sum_valid),
    .sum_vec    (sum_vec)
  );

  // stage 3: round, shift, saturate
  quant_requant u_requant (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .sum_valid (sum_valid),
    .sum_vec   (sum_vec),
    .out_valid (out_valid),
    .out_vec   (out_vec)
  );

endmodule

/* quant_post_tb.sv */
module quant_post_tb;

  logic                 clk;
  logic                 reset;
  logic                 cfg_wr;
  quant_pkg::cfg_addr_t cfg_addr;
  quant_pkg::cfg_data_t cfg_wdata;
  logic                 acc_valid;
  quant_pkg::psum_vec_t acc_vec;
  logic                 out_valid;
  quant_pkg::qout_vec_t out_vec;

  // model copy of the layer config
  quant_pkg::mode_t  m_mode;
  quant_pkg::scale_t m_scale;
  quant_pkg::shift_t m_shift;
  quant_pkg::bias_t  m_bias0;
  quant_pkg::bias_t  m_bias1;

  // rows in flight, expected result and the edge that sampled the row
  quant_pkg::qout_vec_t exp_q[$];
  int                   edge_q[$];

  logic [31:0] lfsr_state;
  logic        timed_out = 1'b0;
  int          edge_count = 0;
  int          errors = 0;
  int          checks = 0;
  int          delivered = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err0 = 0;
  string       test_name = "init";

  quant_post_top DUT (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .acc_valid (acc_valid),
    .acc_vec   (acc_vec),
    .out_valid (out_valid),
    .out_vec   (out_vec)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) edge_count <= edge_count + 1;

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // every lane sign extended from n random bits
  function automatic quant_pkg::psum_vec_t rand_row(input int n);
    quant_pkg::psum_vec_t v;
    logic [31:0]          t;
    for (int i = 0; i < quant_pkg::lanes; i++) begin
      t = rand_bits(n);
      v[i*quant_pkg::psum_width +: quant_pkg::psum_width] =
        quant_pkg::psum_t'($signed(t << (32 - n)) >>> (32 - n));
    end
    return v;
  endfunction

  // exact rounding ties and the psum extremes
  function automatic quant_pkg::psum_vec_t limit_row();
    int                   vals [quant_pkg::lanes];
    quant_pkg::psum_vec_t v;
    vals = '{65536, -65536, 196608, -196608, 8388607, -8388608, 0, 1};
    for (int i = 0; i < quant_pkg::lanes; i++) begin
      v[i*quant_pkg::psum_width +: quant_pkg::psum_width] = quant_pkg::psum_t'(vals[i]);
    end
    return v;
  endfunction

  function automatic quant_pkg::qout_vec_t model_row(input quant_pkg::psum_vec_t v);
    quant_pkg::qout_vec_t r;
    quant_pkg::psum_t     ps;
    longint               acc;
    longint               bias;
    int                   sh;
    r = '0;
    sh = int'(m_shift);
    for (int i = 0; i < quant_pkg::lanes; i++) begin
      ps = v[i*quant_pkg::psum_width +: quant_pkg::psum_width];
      acc = longint'(ps) * longint'(m_scale);
      bias = (i < quant_pkg::half_lanes) ? longint'(m_bias0) : longint'(m_bias1);
      if (m_mode == quant_pkg::mode_1x8 ||
          (m_mode == quant_pkg::mode_8x8 && i < quant_pkg::half_lanes)) begin
        acc = longint'(quant_pkg::prod_t'(acc + bias));
      end else begin
        acc = 0;
      end
      // round half up, then arithmetic shift
      if (sh > 0) begin
        acc = (acc + (longint'(1) << (sh - 1))) >>> sh;
      end
      if (acc > 127) begin
        acc = 127;
      end else if (acc < -128) begin
        acc = -128;
      end
      r[i*quant_pkg::out_width +: quant_pkg::out_width] = acc[7:0];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_cfg(input quant_pkg::cfg_addr_t addr, input quant_pkg::cfg_data_t data);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wr    <= 1'b0;
    case (addr)
      quant_pkg::addr_mode:  m_mode  = data[3:0];
      quant_pkg::addr_scale: m_scale = data;
      quant_pkg::addr_shift: m_shift = data[4:0];
      default: begin
        m_bias0 = data[7:0];
        m_bias1 = data[15:8];
      end
    endcase
  endtask

  task automatic set_cfg(input quant_pkg::mode_t mode, input quant_pkg::scale_t scale,
                         input quant_pkg::shift_t shift, input quant_pkg::bias_t b0,
                         input quant_pkg::bias_t b1);
    write_cfg(quant_pkg::addr_mode, quant_pkg::cfg_data_t'(mode));
    write_cfg(quant_pkg::addr_scale, scale);
    write_cfg(quant_pkg::addr_shift, quant_pkg::cfg_data_t'(shift));
    write_cfg(quant_pkg::addr_bias, {b1, b0});
  endtask

  task automatic send_row(input quant_pkg::psum_vec_t v);
    @(posedge clk);
    acc_valid <= 1'b1;
    acc_vec   <= v;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      acc_valid <= 1'b0;
    end
  endtask

  // stop issuing and wait for every row in flight
  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk);
    acc_valid <= 1'b0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d rows never came out after %0d cycles", test_name, exp_q.size(), waited);
      timed_out = 1'b1;
      wait (!timed_out);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_row();
    quant_pkg::qout_vec_t exp_v;
    quant_pkg::qout_t     e;
    quant_pkg::qout_t     a;
    int                   exp_edge;
    if (exp_q.size() == 0) begin
      $display("%s: out_valid seen with no row in flight", test_name);
      errors++;
    end else begin
      exp_v = exp_q.pop_front();
      exp_edge = edge_q.pop_front();
      checks++;
      // the output seen here is sampled at the next rising edge
      if (edge_count + 1 - exp_edge != 3) begin
        $display("** Error: %s latency expected 3 actual %0d", test_name,
                 edge_count + 1 - exp_edge);
        errors++;
      end
      for (int i = 0; i < quant_pkg::lanes; i++) begin
        e = exp_v[i*quant_pkg::out_width +: quant_pkg::out_width];
        a = out_vec[i*quant_pkg::out_width +: quant_pkg::out_width];
        checks++;
        if (a !== e) begin
          $display("** Error: %s lane %0d expected %0d actual %0d", test_name, i, e, a);
          errors++;
        end
      end
    end
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      // the row seen here is sampled at the next rising edge
      if (acc_valid) begin
        exp_q.push_back(model_row(acc_vec));
        edge_q.push_back(edge_count + 1);
      end
      if (out_valid) begin
        delivered++;
        check_row();
      end
    end
  end

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
    end
    $display("test %s finished with %0d errors", test_name, errors - test_err0);
  endtask

  initial begin
    wait (timed_out);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    quant_pkg::bias_t b0;
    quant_pkg::bias_t b1;
    int               gap;
    int               d0;
    lfsr_state = 32'hc6e2;
    {m_mode, m_scale, m_shift, m_bias0, m_bias1} = '0;
    reset     = 1'b1;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    acc_valid = 1'b0;
    acc_vec   = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    start_test("reset");
    @(negedge clk);
    checks++;
    if (out_vec !== '0) begin
      $display("** Error: reset out_vec expected 0 actual %h", out_vec);
      errors++;
    end
    idle(10);
    send_row(rand_row(24));
    drain();
    end_test();

    start_test("mode_8x8");
    set_cfg(quant_pkg::mode_8x8, quant_pkg::scale_t'(rand_bits(16)),
            quant_pkg::shift_t'(16 + rand_bits(4)), quant_pkg::bias_t'(rand_bits(8)),
            quant_pkg::bias_t'(rand_bits(8)));
    repeat (40) send_row(rand_row(24));
    drain();
    end_test();

    // small operands so the bias shows in the result
    start_test("mode_1x8");
    b0 = quant_pkg::bias_t'(rand_bits(8));
    b1 = quant_pkg::bias_t'(rand_bits(8));
    if (b1 == b0) begin
      b1 = b0 ^ 8'h5a;
    end
    set_cfg(quant_pkg::mode_1x8, quant_pkg::scale_t'(1 + rand_bits(3)),
            quant_pkg::shift_t'(rand_bits(2)), b0, b1);
    repeat (40) send_row(rand_row(8));
    drain();
    end_test();

    start_test("bad_mode");
    repeat (6) begin
      set_cfg(quant_pkg::mode_t'(2 + rand_bits(8) % 14), quant_pkg::scale_t'(rand_bits(16)),
              quant_pkg::shift_t'(rand_bits(5)), quant_pkg::bias_t'(rand_bits(8)),
              quant_pkg::bias_t'(rand_bits(8)));
      repeat (7) send_row(rand_row(24));
      drain();
    end
    end_test();

    start_test("saturate");
    set_cfg(quant_pkg::mode_1x8, 16'h7fff, 5'd0, 8'd0, 8'd0);
    send_row(limit_row());
    repeat (8) send_row(rand_row(24));
    drain();
    set_cfg(quant_pkg::mode_1x8, 16'h4000, 5'd31, 8'd0, 8'd0);
    send_row(limit_row());
    drain();
    set_cfg(quant_pkg::mode_1x8, 16'h8000, 5'd31, 8'd0, 8'd0);
    send_row(limit_row());
    repeat (8) send_row(rand_row(24));
    drain();
    end_test();

    start_test("stream");
    set_cfg(quant_pkg::mode_1x8, quant_pkg::scale_t'(rand_bits(16)),
            quant_pkg::shift_t'(12 + rand_bits(4)), quant_pkg::bias_t'(rand_bits(8)),
            quant_pkg::bias_t'(rand_bits(8)));
    d0 = delivered;
    repeat (60) begin
      send_row(rand_row(24));
      gap = int'(rand_bits(2));
      idle(gap);
    end
    drain();
    // late duplicates would show up within the pipeline depth
    idle(4);
    if (delivered - d0 != 60) begin
      $display("%s: %0d rows delivered, 60 expected", test_name, delivered - d0);
      errors++;
    end
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* quant_post_top.f */
quant_pkg.sv
quant_cfg_if.sv
quant_cfg_regs.sv
quant_scale_mult.sv
quant_bias_add.sv
quant_requant.sv
quant_post_top.sv
quant_post_tb.sv

/* Makefile */
# Verilator flow for the quantization post-processing path

VERILATOR ?= verilator
TOP       ?= quant_post_tb
RTL_TOP   ?= quant_post_top
FILELIST  ?= quant_post_top.f
TB_SRC    ?= quant_post_tb.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter-out $(TB_SRC),$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
